// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= serial_rv_core_tb
FILELIST  ?= serial_rv_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== instr_decode.sv ====
module instr_decode
   import serial_rv_pkg::*;
(
   input  logic           clk,
   input  logic           i_reset,
   input  logic           i_fetched,
   input  word_t          i_instr,

   output logic           o_decoded,
   output decoded_instr_t o_dec
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   alu_op_t    op;
   logic       use_imm;
   word_t      imm;

   assign opcode = i_instr[6:0];
   assign funct3 = i_instr[14:12];
   assign funct7 = i_instr[31:25];

   assign use_imm = (opcode == opcode_op_imm);
   assign imm     = {{20{i_instr[31]}}, i_instr[31:20]};

   // Operation select, anything outside the kept set retires as a no-op
   always_comb begin
      op = alu_none;
      if (opcode == opcode_op) begin
         if (funct7 == funct7_base) begin
            case (funct3)
               funct3_add: op = alu_add;
               funct3_xor: op = alu_xor;
               funct3_or:  op = alu_or;
               funct3_and: op = alu_and;
               default:    op = alu_none;
            endcase
         end else if (funct7 == funct7_sub && funct3 == funct3_add) begin
            op = alu_sub;
         end
      end else if (opcode == opcode_op_imm) begin
         case (funct3)
            funct3_add: op = alu_add;
            funct3_xor: op = alu_xor;
            funct3_or:  op = alu_or;
            funct3_and: op = alu_and;
            default:    op = alu_none;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_decoded <= 1'b0;
      end else begin
         o_decoded <= i_fetched;
      end
   end

   // Decoded fields, held until the next fetch
   always_ff @(posedge clk) begin
      if (i_fetched) begin
         o_dec.op      <= op;
         o_dec.use_imm <= use_imm;
         o_dec.rd      <= i_instr[11:7];
         o_dec.rs1     <= i_instr[19:15];
         o_dec.rs2     <= i_instr[24:20];
         o_dec.imm     <= imm;
      end
   end

endmodule

// ==== instr_fetch.sv ====
module instr_fetch
   import serial_rv_pkg::*;
#(
   parameter word_t RESET_PC = 32'h0
) (
   input  logic  clk,
   input  logic  i_reset,
   input  logic  i_done,

   output word_t o_ibus_adr,
   output logic  o_ibus_cyc,
   input  word_t i_ibus_rdt,
   input  logic  i_ibus_ack,

   output logic  o_fetched,
   output word_t o_instr
);

   logic ack;

   assign ack = o_ibus_cyc & i_ibus_ack;

   // PC and bus cycle level
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_ibus_adr <= RESET_PC;
         o_ibus_cyc <= 1'b1;
      end else begin
         if (ack) begin
            o_ibus_cyc <= 1'b0;
         end
         // Next sequential instruction once the current one retires
         if (i_done) begin
            o_ibus_adr <= o_ibus_adr + 32'd4;
            o_ibus_cyc <= 1'b1;
         end
      end
   end

   // Word is valid only in the ack cycle, decode registers it
   assign o_fetched = ack;
   assign o_instr   = i_ibus_rdt;

endmodule

// ==== rf_sequencer.sv ====
module rf_sequencer
   import serial_rv_pkg::*;
#(
   parameter int W = 1
) (
   input  logic           clk,
   input  logic           i_reset,
   input  logic           i_decoded,
   input  decoded_instr_t i_dec,
   input  logic           i_rf_ready,

   output logic           o_rf_rreq,
   output rf_read_t       o_rf_read,
   output rf_write_t      o_rf_write,
   output logic           o_cnt_en,
   output logic           o_cnt0,
   output logic           o_done
);

   localparam int N_CHUNKS = xlen / W;
   localparam int CNT_W    = $clog2(N_CHUNKS);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(N_CHUNKS - 1);

   logic             waiting;
   logic             ready_ok;
   logic [CNT_W-1:0] cnt;

   // Ready may only be taken once a request is outstanding
   assign ready_ok = (waiting | o_rf_rreq) & i_rf_ready;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_rf_rreq <= 1'b0;
         waiting   <= 1'b0;
         o_cnt_en  <= 1'b0;
         cnt       <= '0;
      end else begin
         o_rf_rreq <= i_decoded;

         if (o_rf_rreq) begin
            waiting <= 1'b1;
         end
         if (ready_ok) begin
            waiting  <= 1'b0;
            o_cnt_en <= 1'b1;
         end

         // Chunk counter wraps to zero on the last chunk
         if (o_cnt_en) begin
            cnt <= cnt + 1'b1;
            if (cnt == CNT_LAST) begin
               cnt      <= '0;
               o_cnt_en <= 1'b0;
            end
         end
      end
   end

   assign o_cnt0 = o_cnt_en & (cnt == '0);
   assign o_done = o_cnt_en & (cnt == CNT_LAST);

   // Register indices come straight from the held decode
   assign o_rf_read.rreg0 = i_dec.rs1;
   assign o_rf_read.rreg1 = i_dec.rs2;

   // No write for no-ops or x0
   assign o_rf_write.wen  = o_cnt_en & (i_dec.op != alu_none) & (i_dec.rd != 5'd0);
   assign o_rf_write.wreg = i_dec.rd;

endmodule

// ==== serial_alu.sv ====
module serial_alu
   import serial_rv_pkg::*;
#(
   parameter int W = 1
) (
   input  logic           clk,
   input  logic           i_reset,
   input  decoded_instr_t i_dec,
   input  logic           i_cnt_en,
   input  logic           i_cnt0,
   input  logic [W-1:0]   i_rdata0,
   input  logic [W-1:0]   i_rdata1,

   output logic [W-1:0]   o_wdata
);

   word_t        imm_sr;
   logic [W-1:0] imm_chunk;
   logic [W-1:0] op_b;
   logic [W-1:0] op_b_add;
   logic         is_sub;
   logic         carry;
   logic         carry_in;
   logic [W:0]   sum;

   // Chunk 0 comes straight from decode, later chunks from the shifter
   assign imm_chunk = i_cnt0 ? i_dec.imm[W-1:0] : imm_sr[W-1:0];

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         if (i_cnt0) begin
            imm_sr <= i_dec.imm >> W;
         end else begin
            imm_sr <= imm_sr >> W;
         end
      end
   end

   assign op_b = i_dec.use_imm ? imm_chunk : i_rdata1;

   // Subtract as rs1 + ~b + 1
   assign is_sub   = (i_dec.op == alu_sub);
   assign op_b_add = is_sub ? ~op_b : op_b;
   assign carry_in = i_cnt0 ? is_sub : carry;
   assign sum      = {1'b0, i_rdata0} + {1'b0, op_b_add} + {{W{1'b0}}, carry_in};

   always_ff @(posedge clk) begin
      if (i_reset) begin
         carry <= 1'b0;
      end else if (i_cnt_en) begin
         carry <= sum[W];
      end
   end

   always_comb begin
      case (i_dec.op)
         alu_add,
         alu_sub: o_wdata = sum[W-1:0];
         alu_and: o_wdata = i_rdata0 & op_b;
         alu_or:  o_wdata = i_rdata0 | op_b;
         alu_xor: o_wdata = i_rdata0 ^ op_b;
         default: o_wdata = '0;
      endcase
   end

endmodule

// ==== serial_rv_core.f ====
serial_rv_pkg.sv
instr_fetch.sv
instr_decode.sv
rf_sequencer.sv
serial_alu.sv
serial_rv_core.sv
serial_rv_core_asserts.sv
serial_rv_core_tb.sv

// ==== serial_rv_core.sv ====
module serial_rv_core
   import serial_rv_pkg::*;
#(
   parameter int    W        = 1,
   parameter word_t RESET_PC = 32'h0
) (
   input  logic         clk,
   input  logic         i_reset,

   // Instruction bus
   output word_t        o_ibus_adr,
   output logic         o_ibus_cyc,
   input  word_t        i_ibus_rdt,
   input  logic         i_ibus_ack,

   // Register file
   output logic         o_rf_rreq,
   input  logic         i_rf_ready,
   output rf_read_t     o_rf_read,
   output rf_write_t    o_rf_write,
   output logic [W-1:0] o_wdata,
   input  logic [W-1:0] i_rdata0,
   input  logic [W-1:0] i_rdata1
);

   logic           fetched;
   word_t          instr;
   logic           decoded;
   decoded_instr_t dec;
   logic           cnt_en;
   logic           cnt0;
   logic           done;

   instr_fetch #(
      .RESET_PC (RESET_PC)
   ) u_fetch (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_done     (done),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_fetched  (fetched),
      .o_instr    (instr)
   );

   instr_decode u_decode (
      .clk       (clk),
      .i_reset   (i_reset),
      .i_fetched (fetched),
      .i_instr   (instr),
      .o_decoded (decoded),
      .o_dec     (dec)
   );

   rf_sequencer #(
      .W (W)
   ) u_seq (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_decoded  (decoded),
      .i_dec      (dec),
      .i_rf_ready (i_rf_ready),
      .o_rf_rreq  (o_rf_rreq),
      .o_rf_read  (o_rf_read),
      .o_rf_write (o_rf_write),
      .o_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_done     (done)
   );

   serial_alu #(
      .W (W)
   ) u_alu (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_dec    (dec),
      .i_cnt_en (cnt_en),
      .i_cnt0   (cnt0),
      .i_rdata0 (i_rdata0),
      .i_rdata1 (i_rdata1),
      .o_wdata  (o_wdata)
   );

endmodule

// ==== serial_rv_core_asserts.sv ====
module serial_rv_core_asserts
   import serial_rv_pkg::*;
#(
   parameter int W = 1
) (
   input logic clk,
   input logic i_reset,
   input logic i_rf_rreq,
   input logic i_rf_ready,
   input logic i_cnt_en,
   input logic i_done,
   input logic i_wen
);

   localparam int N_CHUNKS = xlen / W;

   int unsigned fail_count = 0;

   // Count cycles start only on a ready taken at the previous edge
   a_cnt_after_ready: assert property (@(posedge clk) disable iff (i_reset)
      $rose(i_cnt_en) |-> $past(i_rf_ready))
   else begin
      $error("count cycles started without a ready from the register file");
      fail_count++;
   end

   a_no_req_in_cnt: assert property (@(posedge clk) disable iff (i_reset)
      i_rf_rreq |-> !i_cnt_en)
   else begin
      $error("read request raised during count cycles");
      fail_count++;
   end

   // Write enable opens after ready and closes after done
   a_wen_start: assert property (@(posedge clk) disable iff (i_reset)
      $rose(i_wen) |-> $past(i_rf_ready))
   else begin
      $error("write enable rose without a ready from the register file");
      fail_count++;
   end

   a_wen_end: assert property (@(posedge clk) disable iff (i_reset)
      $fell(i_wen) |-> $past(i_done))
   else begin
      $error("write enable dropped before the last count cycle");
      fail_count++;
   end

   // Last chunk flagged exactly at the end of the word
   a_done_timing: assert property (@(posedge clk) disable iff (i_reset)
      $rose(i_cnt_en) |-> ##(N_CHUNKS - 1) i_done)
   else begin
      $error("done not seen on the last count cycle");
      fail_count++;
   end

   a_cnt_stops: assert property (@(posedge clk) disable iff (i_reset)
      i_done |=> !i_cnt_en)
   else begin
      $error("count cycles continued after done");
      fail_count++;
   end

endmodule

// ==== serial_rv_core_tb.sv ====
module serial_rv_core_tb
   import serial_rv_pkg::*;
();

   localparam int    W           = 2;
   localparam word_t RESET_PC    = 32'h100;
   localparam int    N_CHUNKS    = xlen / W;
   localparam int    N_INSTR     = 400;
   localparam int    RESET_CYC   = 8;
   localparam int    TIMEOUT_CYC = N_INSTR * 50;

   typedef enum {rf_idle, rf_wait_ready, rf_stream} rf_state_t;

   logic         clk = 1'b0;
   logic         i_reset;
   word_t        o_ibus_adr;
   logic         o_ibus_cyc;
   word_t        i_ibus_rdt;
   logic         i_ibus_ack;
   logic         o_rf_rreq;
   logic         i_rf_ready;
   rf_read_t     o_rf_read;
   rf_write_t    o_rf_write;
   logic [W-1:0] o_wdata;
   logic [W-1:0] i_rdata0;
   logic [W-1:0] i_rdata1;

   word_t     program_mem [N_INSTR];
   word_t     rf_mem [32];
   word_t     model_regs [32];
   integer    seed;
   int        cycles;
   int        fetch_idx;
   int        bus_wait;
   int        rf_wait;
   int        rf_chunk;
   int        wr_cnt;
   int        mismatches;
   int        failures;
   int        checks;
   rf_state_t rf_state;
   word_t     op_a;
   word_t     op_b;
   word_t     wr_word;
   word_t     exp_val;
   reg_addr_t exp_rd;
   logic      exp_wr;
   logic      write_seen;
   logic      run_done;
   logic      timed_out;

   serial_rv_core #(
      .W        (W),
      .RESET_PC (RESET_PC)
   ) u_dut (
      .clk        (clk),
      .i_reset    (i_reset),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_rf_rreq  (o_rf_rreq),
      .i_rf_ready (i_rf_ready),
      .o_rf_read  (o_rf_read),
      .o_rf_write (o_rf_write),
      .o_wdata    (o_wdata),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1)
   );

   bind rf_sequencer serial_rv_core_asserts #(
      .W (W)
   ) u_asserts (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_rf_rreq  (o_rf_rreq),
      .i_rf_ready (i_rf_ready),
      .i_cnt_en   (o_cnt_en),
      .i_done     (o_done),
      .i_wen      (o_rf_write.wen)
   );

   always #2 clk = ~clk;

   task automatic check_fetch_addr(input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at time %0t: o_ibus_adr got %h expected %h", $time, got, exp);
      end
   endtask

   task automatic check_result(input reg_addr_t rd, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at time %0t: x%0d got %h expected %h", $time, rd, got, exp);
      end
   endtask

   task automatic check_write_reg(input reg_addr_t got, input reg_addr_t exp);
      checks++;
      if (got !== exp) begin
         mismatches++;
         $display("mismatch at time %0t: o_rf_write.wreg got x%0d expected x%0d",
                  $time, got, exp);
      end
   endtask

   task automatic report_failure(input string msg);
      failures++;
      $display("error at time %0t: %s", $time, msg);
   endtask

   // Random word with about one in ten outside the supported set
   function automatic word_t random_instr();
      word_t w;
      int    pick;
      w    = $random(seed);
      pick = $unsigned($random(seed)) % 10;
      if (pick == 0) begin
         case ($unsigned($random(seed)) % 3)
            0: w[6:0] = 7'b0000011;
            1: begin
               w[6:0]   = opcode_op;
               w[14:12] = 3'b001;
               w[31:25] = 7'h00;
            end
            default: begin
               w[6:0]   = opcode_op_imm;
               w[14:12] = 3'b010;
            end
         endcase
      end else begin
         pick     = $unsigned($random(seed)) % 9;
         w[6:0]   = (pick < 5) ? opcode_op : opcode_op_imm;
         w[31:25] = (pick == 1) ? 7'h20 : (pick < 5) ? 7'h00 : w[31:25];
         case (pick)
            0, 1, 5: w[14:12] = 3'b000;
            2, 6:    w[14:12] = 3'b111;
            3, 7:    w[14:12] = 3'b110;
            default: w[14:12] = 3'b100;
         endcase
      end
      return w;
   endfunction

   // Reference execution on the model's own registers
   task automatic model_exec(input word_t instr, output logic wr, output reg_addr_t rd,
                             output word_t value);
      logic [2:0] f3;
      logic [6:0] f7;
      word_t      a;
      word_t      b;
      logic       valid;
      f3    = instr[14:12];
      f7    = instr[31:25];
      rd    = instr[11:7];
      a     = model_regs[instr[19:15]];
      b     = (instr[6:0] == opcode_op) ? model_regs[instr[24:20]]
                                        : {{20{instr[31]}}, instr[31:20]};
      valid = 1'b0;
      value = '0;
      if (instr[6:0] == opcode_op_imm || (instr[6:0] == opcode_op && f7 == 7'h00)) begin
         valid = (f3 == 3'b000) || (f3 == 3'b100) || (f3 == 3'b110) || (f3 == 3'b111);
         case (f3)
            3'b000:  value = a + b;
            3'b100:  value = a ^ b;
            3'b110:  value = a | b;
            default: value = a & b;
         endcase
      end else if (instr[6:0] == opcode_op && f7 == 7'h20 && f3 == 3'b000) begin
         valid = 1'b1;
         value = a - b;
      end
      wr = valid && (rd != 5'd0);
      if (wr) begin
         model_regs[rd] = value;
      end
   endtask

   task automatic check_retired();
      if (wr_cnt != 0) begin
         report_failure("register write stopped part way through a word");
      end
      if (exp_wr && !write_seen) begin
         report_failure($sformatf("no write to x%0d for the previous instruction", exp_rd));
      end
   endtask

   task automatic drive_ibus();
      if (i_ibus_ack) begin
         i_ibus_ack = 1'b0;
      end else if (o_ibus_cyc && fetch_idx == N_INSTR) begin
         check_retired();
         run_done = 1'b1;
      end else if (o_ibus_cyc) begin
         if (bus_wait < 0) begin
            bus_wait = $unsigned($random(seed)) % 4;
         end
         if (bus_wait == 0) begin
            check_fetch_addr(o_ibus_adr, RESET_PC + 32'(4 * fetch_idx));
            check_retired();
            model_exec(program_mem[fetch_idx], exp_wr, exp_rd, exp_val);
            write_seen = 1'b0;
            i_ibus_rdt = program_mem[fetch_idx];
            i_ibus_ack = 1'b1;
            fetch_idx++;
         end
         bus_wait--;
      end
   endtask

   // Operands sampled at the request and streamed one chunk per count cycle
   task automatic drive_rf();
      i_rf_ready = 1'b0;
      case (rf_state)
         rf_idle: begin
            if (o_rf_rreq) begin
               op_a     = rf_mem[o_rf_read.rreg0];
               op_b     = rf_mem[o_rf_read.rreg1];
               rf_wait  = 1 + $unsigned($random(seed)) % 4;
               rf_state = rf_wait_ready;
            end
         end
         rf_wait_ready: begin
            rf_wait--;
            if (rf_wait == 0) begin
               i_rf_ready = 1'b1;
               rf_chunk   = 0;
               rf_state   = rf_stream;
            end
         end
         default: begin
            i_rdata0 = op_a[rf_chunk*W +: W];
            i_rdata1 = op_b[rf_chunk*W +: W];
            rf_chunk++;
            if (rf_chunk == N_CHUNKS) begin
               rf_state = rf_idle;
            end
         end
      endcase
   endtask

   always @(negedge clk) begin
      cycles++;
      if (!i_reset && !run_done) begin
         drive_ibus();
         drive_rf();
      end
      if (cycles == RESET_CYC) begin
         i_reset = 1'b0;
      end
      if (cycles >= TIMEOUT_CYC) begin
         timed_out = 1'b1;
      end
   end

   // Write port assembled from the serial chunks
   always @(posedge clk) begin
      if (!i_reset && o_rf_write.wen) begin
         if (wr_cnt == 0 && !exp_wr) begin
            report_failure($sformatf("unexpected write to x%0d", o_rf_write.wreg));
         end
         wr_word[wr_cnt*W +: W] = o_wdata;
         wr_cnt++;
         if (wr_cnt == N_CHUNKS) begin
            if (exp_wr) begin
               check_write_reg(o_rf_write.wreg, exp_rd);
               check_result(exp_rd, wr_word, exp_val);
            end
            rf_mem[o_rf_write.wreg] = wr_word;
            write_seen = 1'b1;
            wr_cnt     = 0;
         end
      end
   end

   initial begin
      seed       = 32'h7fa5ae22;
      i_reset    = 1'b1;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_rf_ready = 1'b0;
      i_rdata0   = '0;
      i_rdata1   = '0;
      cycles     = 0;
      fetch_idx  = 0;
      bus_wait   = -1;
      rf_wait    = 0;
      rf_chunk   = 0;
      wr_cnt     = 0;
      mismatches = 0;
      failures   = 0;
      checks     = 0;
      rf_state   = rf_idle;
      exp_wr     = 1'b0;
      exp_rd     = '0;
      exp_val    = '0;
      write_seen = 1'b0;
      run_done   = 1'b0;
      timed_out  = 1'b0;
      for (int i = 0; i < 32; i++) begin
         rf_mem[i]     = (i == 0) ? '0 : word_t'($random(seed));
         model_regs[i] = rf_mem[i];
      end
      for (int i = 0; i < N_INSTR; i++) begin
         program_mem[i] = random_instr();
      end

      wait (run_done || timed_out);
      if (timed_out && !run_done) begin
         report_failure($sformatf("timeout after %0d cycles, %0d of %0d instructions fetched",
                                  cycles, fetch_idx, N_INSTR));
      end
      for (int i = 0; i < 32; i++) begin
         check_result(reg_addr_t'(i), rf_mem[i], model_regs[i]);
      end
      $display("errors: %0d mismatches, %0d other failures, %0d assertion failures, %0d checks",
               mismatches, failures, u_dut.u_seq.u_asserts.fail_count, checks);
      if (mismatches == 0 && failures == 0 && u_dut.u_seq.u_asserts.fail_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== serial_rv_pkg.sv ====
package serial_rv_pkg;

   localparam int xlen = 32;

   typedef logic [xlen-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;

   // Kept major opcodes
   localparam logic [6:0] opcode_op     = 7'b0110011;
   localparam logic [6:0] opcode_op_imm = 7'b0010011;

   // funct3 values shared by the register and immediate forms
   localparam logic [2:0] funct3_add = 3'b000;
   localparam logic [2:0] funct3_xor = 3'b100;
   localparam logic [2:0] funct3_or  = 3'b110;
   localparam logic [2:0] funct3_and = 3'b111;

   // funct7 for OP, SUB sets bit 30
   localparam logic [6:0] funct7_base = 7'b0000000;
   localparam logic [6:0] funct7_sub  = 7'b0100000;

   typedef enum logic [2:0] {
      alu_none,
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor
   } alu_op_t;

   typedef struct packed {
      alu_op_t   op;
      logic      use_imm;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      // Sign-extended I-type immediate
      word_t     imm;
   } decoded_instr_t;

   typedef struct packed {
      reg_addr_t rreg0;
      reg_addr_t rreg1;
   } rf_read_t;

   typedef struct packed {
      logic      wen;
      reg_addr_t wreg;
   } rf_write_t;

endpackage
